//--- rtl/dino_consts.svh
`ifndef DINO_CONSTS_SVH
`define DINO_CONSTS_SVH

// Playfield
`define DINO_GROUND_Y    350
`define DINO_X           160

// Dino boxes
`define DINO_W           34
`define DINO_H           40
`define DINO_DUCK_W      48
`define DINO_DUCK_H      38
`define DINO_DUCK_TRIM   12
`define DINO_STAND_Y     (`DINO_GROUND_Y - `DINO_H)      // 310
`define DINO_DUCK_Y      (`DINO_GROUND_Y - `DINO_DUCK_H) // 312

// Vertical motion
`define DINO_JUMP_VEL    18
`define DINO_GRAVITY     1
`define DINO_FAST_FALL   3

// Obstacle boxes
`define CACTUS_S_W       14
`define CACTUS_S_H       30
`define CACTUS_B_W       20
`define CACTUS_B_H       40
`define PTERO_W          36
`define PTERO_H          34
`define PTERO_FLY_OFFSET 30

// Obstacle motion and spawning
`define OBS_SPEED        4
`define OBS_FIRST_X      630
`define OBS_SPAWN_X      640
`define OBS_MIN_GAP      300
`define OBS_SPAWN_LIMIT  (`OBS_SPAWN_X - `OBS_MIN_GAP)   // 340
`define OBS_RETIRE_X     (-40)
`define OBS_SLOTS        3

// Random source
`define LFSR_SEED        10'h2b5

`endif

//--- rtl/dino_game_top.sv
`timescale 1ns/1ps

module dino_game_top (
    input  logic                  pclk,
    input  logic                  rst,
    input  logic                  start_pulse,
    input  logic                  pause_pulse,
    input  logic                  jump,
    input  logic                  duck,
    input  logic                  vsync,
    output dino_pkg::game_state_t game_state,
    output dino_pkg::ycoord_t     dino_y,
    output logic                  jumped,
    output logic                  ducking,
    output logic [2:0]            obs_active
);

    logic                frame_step; // One per vsync in run
    logic                restart;    // Start from the over state
    logic                collision;
    dino_pkg::xcoord_t   obs_x [3];
    dino_pkg::obs_kind_t obs_kind [3];

    game_fsm u_fsm (
        .pclk        (pclk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .pause_pulse (pause_pulse),
        .vsync       (vsync),
        .collision   (collision),
        .state       (game_state),
        .frame_step  (frame_step),
        .restart     (restart)
    );

    dino_physics u_physics (
        .pclk       (pclk),
        .rst        (rst),
        .frame_step (frame_step),
        .restart    (restart),
        .jump       (jump),
        .duck       (duck),
        .dino_y     (dino_y),
        .jumped     (jumped),
        .ducking    (ducking)
    );

    obstacle_field u_obstacles (
        .pclk       (pclk),
        .rst        (rst),
        .frame_step (frame_step),
        .restart    (restart),
        .obs_x      (obs_x),
        .obs_kind   (obs_kind),
        .obs_active (obs_active)
    );

    // Combinational, back into the FSM
    hit_detect u_hit (
        .dino_y     (dino_y),
        .ducking    (ducking),
        .obs_x      (obs_x),
        .obs_kind   (obs_kind),
        .obs_active (obs_active),
        .collision  (collision)
    );

endmodule

//--- rtl/dino_physics.sv
`timescale 1ns/1ps

`include "dino_consts.svh"

module dino_physics (
    input  logic              pclk,
    input  logic              rst,
    input  logic              frame_step,
    input  logic              restart,
    input  logic              jump,
    input  logic              duck,
    output dino_pkg::ycoord_t dino_y,
    output logic              jumped,
    output logic              ducking
);

    import dino_pkg::*;

    vel_t dino_vel;
    logic on_ground;

    // Standing or ducking row counts as ground
    assign on_ground = dino_y >= ycoord_t'(`DINO_STAND_Y);

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            dino_y   <= ycoord_t'(`DINO_STAND_Y);
            dino_vel <= '0;
            jumped   <= 1'b0;
            ducking  <= 1'b0;
        end else if (restart) begin
            dino_y   <= ycoord_t'(`DINO_STAND_Y);
            dino_vel <= '0;
            jumped   <= 1'b0;
            ducking  <= 1'b0;
        end else if (frame_step) begin
            if (on_ground) begin
                if (jump) begin
                    // Take off, first step already applied
                    dino_vel <= -vel_t'(`DINO_JUMP_VEL);
                    dino_y   <= dino_y - ycoord_t'(`DINO_JUMP_VEL);
                    jumped   <= 1'b1;
                    ducking  <= 1'b0;
                end else if (duck) begin
                    dino_vel <= '0;
                    dino_y   <= ycoord_t'(`DINO_DUCK_Y); // Lower sprite row
                    jumped   <= 1'b0;
                    ducking  <= 1'b1;
                end else begin
                    dino_vel <= '0;
                    dino_y   <= ycoord_t'(`DINO_STAND_Y); // Also snaps a landing
                    jumped   <= 1'b0;
                    ducking  <= 1'b0;
                end
            end else begin
                // Airborne, old velocity moves the dino
                dino_y <= dino_y + ycoord_t'(dino_vel);
                if (duck) begin
                    dino_vel <= dino_vel + vel_t'(`DINO_FAST_FALL); // Fast fall
                end else begin
                    dino_vel <= dino_vel + vel_t'(`DINO_GRAVITY);
                end
                jumped  <= 1'b1;
                ducking <= 1'b0; // Duck in the air only speeds the fall
            end
        end
    end

    // Pose flags are exclusive
    a_pose_exclusive : assert property (
        @(posedge pclk) disable iff (rst) !(ducking && jumped)
    );

endmodule

//--- rtl/dino_pkg.sv
package dino_pkg;

    // Game FSM states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RUN   = 2'd1,
        ST_OVER  = 2'd2,
        ST_PAUSE = 2'd3
    } game_state_t;

    // Obstacle kinds, code 3 never stored
    typedef enum logic [1:0] {
        OBS_CACTUS_S = 2'd0,
        OBS_CACTUS_B = 2'd1,
        OBS_PTERO    = 2'd2
    } obs_kind_t;

    typedef logic [9:0]         ycoord_t; // Screen row, 0 at top
    typedef logic signed [12:0] xcoord_t; // Goes negative off the left edge
    typedef logic signed [9:0]  vel_t;    // Pixels per frame, negative is up

endpackage

//--- rtl/game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
    input  logic                  pclk,
    input  logic                  rst,
    input  logic                  start_pulse,
    input  logic                  pause_pulse,
    input  logic                  vsync,
    input  logic                  collision,
    output dino_pkg::game_state_t state,
    output logic                  frame_step,
    output logic                  restart
);

    import dino_pkg::*;

    logic        vsync_q;    // Last vsync sample
    logic        vsync_rise;
    game_state_t state_next;

    assign vsync_rise = vsync && !vsync_q;

    // Strobes only in the states that use them
    assign frame_step = vsync_rise && (state == ST_RUN);
    assign restart    = start_pulse && (state == ST_OVER);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start_pulse) state_next = ST_RUN;
            end
            ST_RUN: begin
                // Hit wins over a pause request
                if (collision) begin
                    state_next = ST_OVER;
                end else if (pause_pulse) begin
                    state_next = ST_PAUSE;
                end
            end
            ST_PAUSE: begin
                if (pause_pulse) state_next = ST_RUN;
            end
            ST_OVER: begin
                if (start_pulse) state_next = ST_IDLE; // Same edge as restart
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            vsync_q <= 1'b0;
        end else begin
            state   <= state_next;
            vsync_q <= vsync; // Sampled every clock, not only in run
        end
    end

    // Physics and obstacles never see a move and a clear at once
    a_no_step_on_restart : assert property (
        @(posedge pclk) disable iff (rst) !(restart && frame_step)
    );

    // A run always starts before it can end
    a_no_idle_to_over : assert property (
        @(posedge pclk) disable iff (rst) (state == ST_IDLE) |=> (state != ST_OVER)
    );

endmodule

//--- rtl/hit_detect.sv
`timescale 1ns/1ps

`include "dino_consts.svh"

module hit_detect (
    input  dino_pkg::ycoord_t     dino_y,
    input  logic                  ducking,
    input  dino_pkg::xcoord_t     obs_x [`OBS_SLOTS],
    input  dino_pkg::obs_kind_t   obs_kind [`OBS_SLOTS],
    input  logic [`OBS_SLOTS-1:0] obs_active,
    output logic                  collision
);

    import dino_pkg::*;

    logic signed [13:0] dino_right;  // One past the right column
    logic signed [13:0] obs_left;
    logic signed [13:0] obs_right;
    ycoord_t            col_top;     // Collision box top row
    ycoord_t            col_bot;     // One past the bottom row
    logic               x_hit;
    logic               y_hit;

    // Ducking box is wider, its top trimmed down
    always_comb begin
        if (ducking) begin
            dino_right = 14'sd`DINO_X + 14'sd`DINO_DUCK_W;
            col_top    = dino_y + ycoord_t'(`DINO_DUCK_TRIM);
            col_bot    = dino_y + ycoord_t'(`DINO_DUCK_H);
        end else begin
            dino_right = 14'sd`DINO_X + 14'sd`DINO_W;
            col_top    = dino_y;
            col_bot    = dino_y + ycoord_t'(`DINO_H);
        end
    end

    always_comb begin
        collision = 1'b0;
        obs_left  = '0;
        obs_right = '0;
        x_hit     = 1'b0;
        y_hit     = 1'b0;
        for (int i = 0; i < `OBS_SLOTS; i++) begin
            obs_left = 14'(obs_x[i]); // Sign extended
            case (obs_kind[i])
                OBS_CACTUS_S: begin
                    obs_right = obs_left + 14'sd`CACTUS_S_W;
                    y_hit     = col_bot > ycoord_t'(`DINO_GROUND_Y - `CACTUS_S_H);
                end
                OBS_CACTUS_B: begin
                    obs_right = obs_left + 14'sd`CACTUS_B_W;
                    y_hit     = col_bot > ycoord_t'(`DINO_GROUND_Y - `CACTUS_B_H);
                end
                default: begin
                    // Flying box, can be passed underneath
                    obs_right = obs_left + 14'sd`PTERO_W;
                    y_hit     = (col_bot > ycoord_t'(`DINO_GROUND_Y - `PTERO_H
                                                     - `PTERO_FLY_OFFSET))
                             && (col_top < ycoord_t'(`DINO_GROUND_Y - `PTERO_FLY_OFFSET));
                end
            endcase
            x_hit = (dino_right > obs_left) && (14'sd`DINO_X < obs_right);
            if (obs_active[i] && x_hit && y_hit) begin
                collision = 1'b1;
            end
        end
    end

endmodule

//--- rtl/lfsr_10.sv
`timescale 1ns/1ps

`include "dino_consts.svh"

module lfsr_10 (
    input  logic       pclk,
    input  logic       rst,
    output logic [9:0] random_out
);

    logic [9:0] lfsr_q;
    logic       feedback;

    // x^10 + x^7 + 1, maximal length
    assign feedback = lfsr_q[9] ^ lfsr_q[6];

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            lfsr_q <= `LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[8:0], feedback}; // Shift every clock
        end
    end

    assign random_out = lfsr_q;

    // All-zero state would lock up the sequence
    a_lfsr_nonzero : assert property (
        @(posedge pclk) disable iff (rst) lfsr_q != 10'd0
    );

endmodule

//--- rtl/obstacle_field.sv
`timescale 1ns/1ps

`include "dino_consts.svh"

module obstacle_field (
    input  logic                  pclk,
    input  logic                  rst,
    input  logic                  frame_step,
    input  logic                  restart,
    output dino_pkg::xcoord_t     obs_x [`OBS_SLOTS],
    output dino_pkg::obs_kind_t   obs_kind [`OBS_SLOTS],
    output logic [`OBS_SLOTS-1:0] obs_active
);

    import dino_pkg::*;

    logic [9:0] random_val;
    logic [1:0] last_idx;  // Most recently spawned slot
    logic [1:0] next_idx;  // Round-robin successor
    xcoord_t    x_moved [`OBS_SLOTS];
    obs_kind_t  new_kind;
    logic       spawn;

    lfsr_10 u_lfsr (
        .pclk       (pclk),
        .rst        (rst),
        .random_out (random_val)
    );

    assign next_idx = (last_idx == 2'(`OBS_SLOTS - 1)) ? 2'd0 : last_idx + 2'd1;

    // Positions after this frame's shift
    always_comb begin
        for (int i = 0; i < `OBS_SLOTS; i++) begin
            x_moved[i] = obs_x[i] - xcoord_t'(`OBS_SPEED);
        end
    end

    // Top LFSR bits pick the kind, 2 and 3 both fly
    assign new_kind = random_val[9] ? OBS_PTERO : obs_kind_t'({1'b0, random_val[8]});

    // Gap measured behind the last entry, successor must be free
    assign spawn = (x_moved[last_idx] < `OBS_SPAWN_LIMIT) && !obs_active[next_idx];

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `OBS_SLOTS; i++) begin
                obs_x[i]    <= xcoord_t'(`OBS_FIRST_X);
                obs_kind[i] <= OBS_CACTUS_S;
            end
            obs_active <= `OBS_SLOTS'(1); // Slot 0 waits on screen
            last_idx   <= 2'd0;
        end else if (restart) begin
            for (int i = 0; i < `OBS_SLOTS; i++) begin
                obs_x[i]    <= xcoord_t'(`OBS_FIRST_X);
                obs_kind[i] <= OBS_CACTUS_S;
            end
            obs_active <= `OBS_SLOTS'(1);
            last_idx   <= 2'd0;
        end else if (frame_step) begin
            for (int i = 0; i < `OBS_SLOTS; i++) begin
                obs_x[i] <= x_moved[i]; // Free slots drift too
                if (obs_active[i] && (x_moved[i] < `OBS_RETIRE_X)) begin
                    obs_active[i] <= 1'b0; // Gone off the left edge
                end
            end
            if (spawn) begin
                // Overrides the shift for the entering slot
                obs_x[next_idx]      <= xcoord_t'(`OBS_SPAWN_X);
                obs_kind[next_idx]   <= new_kind;
                obs_active[next_idx] <= 1'b1;
                last_idx             <= next_idx;
            end
        end
    end

    // Slots appear only on a frame or on a restart
    a_activate_on_step : assert property (
        @(posedge pclk) disable iff (rst)
        (|(obs_active & ~$past(obs_active))) |-> $past(frame_step || restart)
    );

endmodule

//--- src.f
+incdir+rtl
+incdir+verif
rtl/dino_pkg.sv
rtl/lfsr_10.sv
rtl/game_fsm.sv
rtl/dino_physics.sv
rtl/obstacle_field.sv
rtl/hit_detect.sv
rtl/dino_game_top.sv
verif/dino_game_tb.sv

//--- verif/dino_tb_table.svh
`ifndef DINO_TB_TABLE_SVH
`define DINO_TB_TABLE_SVH

// Each row holds action, argument (frame count or input level) and the expected
// game_state, dino_y, jumped, ducking and obs_active once the row is done
task automatic load_table();
    add_row(ACT_FRAMES,  0, ST_IDLE,  310, 1'b0, 1'b0, 3'b001); // Straight out of reset
    add_row(ACT_DUCK,    1, ST_IDLE,  310, 1'b0, 1'b0, 3'b001); // Duck held while idle
    add_row(ACT_FRAMES,  3, ST_IDLE,  310, 1'b0, 1'b0, 3'b001); // Idle frames move nothing
    add_row(ACT_DUCK,    0, ST_IDLE,  310, 1'b0, 1'b0, 3'b001);
    add_row(ACT_START,   0, ST_RUN,   310, 1'b0, 1'b0, 3'b001);
    add_row(ACT_JUMP,    1, ST_RUN,   310, 1'b0, 1'b0, 3'b001);
    add_row(ACT_FRAMES,  1, ST_RUN,   292, 1'b1, 1'b0, 3'b001); // Take-off frame
    add_row(ACT_JUMP,    0, ST_RUN,   292, 1'b1, 1'b0, 3'b001);
    add_row(ACT_FRAMES,  4, ST_RUN,   226, 1'b1, 1'b0, 3'b001); // 274, 257, 241, 226
    add_row(ACT_PAUSE,   0, ST_PAUSE, 226, 1'b1, 1'b0, 3'b001);
    add_row(ACT_FRAMES,  5, ST_PAUSE, 226, 1'b1, 1'b0, 3'b001); // Frozen mid-air
    add_row(ACT_PAUSE,   0, ST_RUN,   226, 1'b1, 1'b0, 3'b001);
    add_row(ACT_FRAMES, 34, ST_RUN,   311, 1'b1, 1'b0, 3'b001); // Lands one row low
    add_row(ACT_FRAMES,  1, ST_RUN,   310, 1'b0, 1'b0, 3'b001); // Snapped to ground

    // Fast fall with duck held in the air
    add_row(ACT_JUMP,    1, ST_RUN,   310, 1'b0, 1'b0, 3'b001);
    add_row(ACT_FRAMES,  1, ST_RUN,   292, 1'b1, 1'b0, 3'b001);
    add_row(ACT_JUMP,    0, ST_RUN,   292, 1'b1, 1'b0, 3'b001);
    add_row(ACT_DUCK,    1, ST_RUN,   292, 1'b1, 1'b0, 3'b001);
    add_row(ACT_FRAMES, 14, ST_RUN,   313, 1'b1, 1'b0, 3'b001);
    add_row(ACT_FRAMES,  3, ST_RUN,   312, 1'b0, 1'b1, 3'b001); // Ducking on the ground
    add_row(ACT_DUCK,    0, ST_RUN,   312, 1'b0, 1'b1, 3'b001);
    add_row(ACT_FRAMES,  1, ST_RUN,   310, 1'b0, 1'b0, 3'b001); // Frame 59

    // Second obstacle slot enters at frame 73
    add_row(ACT_FRAMES, 13, ST_RUN,   310, 1'b0, 1'b0, 3'b001);
    add_row(ACT_FRAMES,  1, ST_RUN,   310, 1'b0, 1'b0, 3'b011);
    add_row(ACT_FRAMES, 36, ST_RUN,   310, 1'b0, 1'b0, 3'b011); // Frame 109 still clear
    add_row(ACT_FRAMES,  1, ST_OVER,  310, 1'b0, 1'b0, 3'b011); // Cactus reaches the dino
    add_row(ACT_JUMP,    1, ST_OVER,  310, 1'b0, 1'b0, 3'b011); // Jump held after the hit
    add_row(ACT_FRAMES,  3, ST_OVER,  310, 1'b0, 1'b0, 3'b011);
    add_row(ACT_JUMP,    0, ST_OVER,  310, 1'b0, 1'b0, 3'b011);
    add_row(ACT_PAUSE,   0, ST_OVER,  310, 1'b0, 1'b0, 3'b011); // Ignored in over
    add_row(ACT_START,   0, ST_IDLE,  310, 1'b0, 1'b0, 3'b001); // Restart clears the field
    add_row(ACT_FRAMES,  2, ST_IDLE,  310, 1'b0, 1'b0, 3'b001);
    add_row(ACT_START,   0, ST_RUN,   310, 1'b0, 1'b0, 3'b001);
    add_row(ACT_FRAMES,  2, ST_RUN,   310, 1'b0, 1'b0, 3'b001);
endtask

`endif

//--- verif/dino_game_tb.sv
`timescale 1ns/1ps

module dino_game_tb;

    import dino_pkg::*;

    typedef enum logic [2:0] {
        ACT_FRAMES, ACT_START, ACT_PAUSE, ACT_JUMP, ACT_DUCK
    } action_t;

    typedef struct packed {
        action_t     act;
        logic [7:0]  arg;     // Frames to run, or level for jump and duck
        game_state_t state;
        logic [9:0]  y;
        logic        jumped;
        logic        ducking;
        logic [2:0]  active;
    } row_t;

    // Game rules for the reference model
    localparam int STAND_Y     = 350 - 40;
    localparam int DUCK_Y      = 350 - 38;
    localparam int JUMP_VEL    = 18;
    localparam int GRAVITY     = 1;
    localparam int FAST_FALL   = 3;
    localparam int FIRST_X     = 630;
    localparam int SPEED       = 4;
    localparam int SPAWN_LIMIT = 640 - 300;
    localparam int DINO_RIGHT  = 160 + 34;
    localparam int SPAWN_FRAME = (FIRST_X - SPAWN_LIMIT) / SPEED + 1; // First frame past 340
    localparam int HIT_FRAME   = (FIRST_X - DINO_RIGHT) / SPEED + 1;  // Cactus inside the box
    localparam int FRAME_CLKS  = 8;

    logic        pclk;
    logic        rst;
    logic        start_pulse;
    logic        pause_pulse;
    logic        jump;
    logic        duck;
    logic        vsync;
    game_state_t game_state;
    ycoord_t     dino_y;
    logic        jumped;
    logic        ducking;
    logic [2:0]  obs_active;

    // Model state
    game_state_t m_state;
    int          m_y;
    int          m_vel;
    int          m_frames;   // Run frames since start
    logic        m_jumped;
    logic        m_ducking;

    row_t rows [0:63];
    int   num_rows    = 0;
    int   cycle_count = 0;
    int   cycle_limit = 200;

    dino_game_top dut (
        .pclk        (pclk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .pause_pulse (pause_pulse),
        .jump        (jump),
        .duck        (duck),
        .vsync       (vsync),
        .game_state  (game_state),
        .dino_y      (dino_y),
        .jumped      (jumped),
        .ducking     (ducking),
        .obs_active  (obs_active)
    );

    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk; // 100 ns period
    end

    // Hang guard
    always @(posedge pclk) begin
        cycle_count = cycle_count + 1;
        assert (cycle_count < cycle_limit) else begin
            $display("timeout: run still busy after %0d clock cycles", cycle_limit);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    task automatic add_row(input action_t act, input int arg, input game_state_t st,
                           input int y, input logic j, input logic d, input logic [2:0] active);
        row_t r;
        r.act     = act;
        r.arg     = arg[7:0];
        r.state   = st;
        r.y       = y[9:0];
        r.jumped  = j;
        r.ducking = d;
        r.active  = active;
        rows[num_rows] = r;
        num_rows++;
    endtask

    `include "dino_tb_table.svh"

    task automatic reset_model();
        m_y       = STAND_Y;
        m_vel     = 0;
        m_jumped  = 1'b0;
        m_ducking = 1'b0;
        m_frames  = 0;
    endtask

    // One frame of dino physics, only while running
    task automatic step_model();
        if (m_state == ST_RUN) begin
            m_frames++;
            if (m_y >= STAND_Y) begin
                m_vel     = jump ? -JUMP_VEL : 0;
                m_y       = jump ? m_y - JUMP_VEL : (duck ? DUCK_Y : STAND_Y);
                m_jumped  = jump;
                m_ducking = !jump && duck;
            end else begin
                m_y       = m_y + m_vel; // Old velocity first
                m_vel     = m_vel + (duck ? FAST_FALL : GRAVITY);
                m_jumped  = 1'b1;
                m_ducking = 1'b0;
            end
            if (m_frames == HIT_FRAME) m_state = ST_OVER;
        end
    endtask

    function automatic logic [2:0] model_active();
        return (m_frames >= SPAWN_FRAME) ? 3'b011 : 3'b001;
    endfunction

    task automatic check_outputs(input game_state_t st, input int y, input logic j,
                                 input logic d, input logic [2:0] active, input string what);
        assert (game_state == st && dino_y == y[9:0] && jumped == j && ducking == d
                && obs_active == active) else begin
            $display("mismatch at %0t: %s, got state %0d y %0d jumped %b ducking %b active %b",
                     $time, what, game_state, dino_y, jumped, ducking, obs_active);
            $display("  expected state %0d y %0d jumped %b ducking %b active %b",
                     st, y, j, d, active);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // vsync high for one clock, frame step taken on the next edge
    task automatic send_frame();
        @(posedge pclk);
        vsync <= 1'b1;
        @(posedge pclk);
        vsync <= 1'b0;
        repeat (FRAME_CLKS - 2) @(posedge pclk);
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        int   k;
        r = rows[idx];
        case (r.act)
            ACT_START: begin
                @(posedge pclk);
                start_pulse <= 1'b1;
                @(posedge pclk);
                start_pulse <= 1'b0;
                if (m_state == ST_IDLE) begin
                    m_state = ST_RUN;
                end else if (m_state == ST_OVER) begin
                    m_state = ST_IDLE; // Restart back to reset values
                    reset_model();
                end
            end
            ACT_PAUSE: begin
                @(posedge pclk);
                pause_pulse <= 1'b1;
                @(posedge pclk);
                pause_pulse <= 1'b0;
                if (m_state == ST_RUN) m_state = ST_PAUSE;
                else if (m_state == ST_PAUSE) m_state = ST_RUN;
            end
            ACT_JUMP: begin
                @(posedge pclk);
                jump <= r.arg[0];
            end
            ACT_DUCK: begin
                @(posedge pclk);
                duck <= r.arg[0];
            end
            default: begin
                for (k = 0; k < r.arg; k++) begin
                    send_frame();
                    step_model();
                    @(negedge pclk);
                    check_outputs(m_state, m_y, m_jumped, m_ducking, model_active(),
                                  $sformatf("row %0d run frame %0d", idx, m_frames));
                end
            end
        endcase
        @(negedge pclk);
        check_outputs(r.state, r.y, r.jumped, r.ducking, r.active,
                      $sformatf("row %0d end of row", idx));
    endtask

    initial begin
        int i;
        rst         = 1'b1;
        start_pulse = 1'b0;
        pause_pulse = 1'b0;
        jump        = 1'b0;
        duck        = 1'b0;
        vsync       = 1'b0;
        void'($urandom(32'he257fcd7));
        load_table();
        cycle_limit = num_rows * FRAME_CLKS * 130 + 200;
        m_state = ST_IDLE;
        reset_model();
        repeat (10) @(posedge pclk);
        rst <= 1'b0;
        for (i = 0; i < num_rows; i++) begin
            apply_row(i);
            repeat ($urandom_range(3, 0)) @(posedge pclk); // Uneven gap between rows
        end
        $display("TB PASSED");
        $finish;
    end

endmodule
